/* Makefile */
# Verilator simulation of the priority bridge

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= priority_bridge_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/bridge_assertions.sv */
//////////////////////////////////////////////////
// bound to priority_bridge, sees its FIFO push and full
//////////////////////////////////////////////////
`timescale 1ns/100ps

module bridge_assertions (
    input logic                           clk,
    input logic                           rst_n,
    input bridge_types_pkg::bridge_item_t out_item,
    input logic                           out_valid,
    input logic                           out_ready,
    input logic                           push,
    input logic                           full
);

    // failing assertion count
    int fail_count = 0;

    // a stalled word stays put
    property hold_while_stalled;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_item);
    endproperty

    property no_push_when_full;
        @(posedge clk) disable iff (!rst_n)
        full |-> !push;
    endproperty

    hold_check: assert property (hold_while_stalled)
        else begin
            $error("out_item changed or dropped while out_ready was low");
            fail_count++;
        end

    push_check: assert property (no_push_when_full)
        else begin
            $error("arbiter pushed into a full FIFO");
            fail_count++;
        end

endmodule

bind priority_bridge bridge_assertions bridge_assertions_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_item  (out_item),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .push      (push),
    .full      (full)
);

/* bench/bridge_tests.svh */
//////////////////////////////////////////////////
// tasks start and return 1 ns after a rising edge
//////////////////////////////////////////////////
`ifndef BRIDGE_TESTS_SVH
`define BRIDGE_TESTS_SVH

// offer one word and hold it until the bridge takes it
task automatic send_beat(input logic is_high, input logic [data_width-1:0] data);
    int   waited;
    logic ready;
    waited = 0;
    ready  = 1'b0;
    if (is_high) begin
        high_beat.valid = 1'b1;
        high_beat.data  = data;
    end else begin
        low_beat.valid = 1'b1;
        low_beat.data  = data;
    end
    while (!ready && waited < 50) begin
        @(negedge clk);
        ready = is_high ? high_ready : low_ready;
        waited++;
    end
    if (!ready) begin
        report_failure(is_high ? "high word was never accepted" : "low word was never accepted");
    end
    @(posedge clk);
    #1;
    if (is_high) begin
        high_beat.valid = 1'b0;
    end else begin
        low_beat.valid = 1'b0;
    end
endtask

// wait until every accepted word has left
task automatic wait_drained();
    int waited;
    waited = 0;
    while ((exp_queue.size() != 0 || out_valid) && waited < 50) begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (exp_queue.size() != 0 || out_valid) begin
        report_failure("bridge did not drain its words");
    end
endtask

task automatic check_reset_state();
    @(negedge clk);
    compare_bit("out_valid", out_valid, 1'b0);
    compare_bit("high_ready", high_ready, 1'b1);
    compare_bit("low_ready", low_ready, 1'b1);
    @(posedge clk);
    #1;
endtask

// one lone word per source, 2 edges from acceptance to out_valid
task automatic run_single_source();
    logic [data_width-1:0] data;
    out_ready = 1'b1;
    for (int src = 1; src >= 0; src--) begin
        data = $random(seed);
        send_beat(src[0], data);
        @(negedge clk);
        compare_bit("out_valid", out_valid, 1'b0);
        @(negedge clk);
        compare_bit("out_valid", out_valid, 1'b1);
        @(posedge clk);
        #1;
        wait_drained();
    end
endtask

task automatic run_strict_priority();
    logic [data_width-1:0] data[3];
    foreach (data[i]) begin
        data[i] = $random(seed);
    end
    accept_log.delete();
    fork
        begin
            send_beat(1'b1, data[0]);
            send_beat(1'b1, data[1]);
        end
        send_beat(1'b0, data[2]);
    join
    wait_drained();
    if (accept_log.size() != 3) begin
        report_failure("strict priority test accepted the wrong number of words");
    end else begin
        compare_bit("from_high", accept_log[0], 1'b1);
        compare_bit("from_high", accept_log[1], 1'b1);
        compare_bit("from_high", accept_log[2], 1'b0);
    end
endtask

// both sources busy, low gets every (limit + 1)th slot
task automatic run_starvation_guard();
    logic [data_width-1:0] high_data[3 * low_wait_limit];
    logic [data_width-1:0] low_data[3];
    foreach (high_data[i]) begin
        high_data[i] = $random(seed);
    end
    foreach (low_data[i]) begin
        low_data[i] = $random(seed);
    end
    accept_log.delete();
    fork
        for (int i = 0; i < 3 * low_wait_limit; i++) begin
            send_beat(1'b1, high_data[i]);
        end
        for (int i = 0; i < 3; i++) begin
            send_beat(1'b0, low_data[i]);
        end
    join
    wait_drained();
    if (accept_log.size() != 3 * (low_wait_limit + 1)) begin
        report_failure("starvation test accepted the wrong number of words");
    end else begin
        foreach (accept_log[i]) begin
            compare_bit("from_high", accept_log[i], (i % (low_wait_limit + 1)) != low_wait_limit);
        end
    end
endtask

task automatic run_back_pressure();
    logic [data_width-1:0] data[fifo_depth + 3];
    int                    start_count;
    foreach (data[i]) begin
        data[i] = $random(seed);
    end
    accept_log.delete();
    start_count = delivered;
    out_ready   = 1'b0;
    fork
        foreach (data[i]) begin
            send_beat(1'b1, data[i]);
        end
        begin
            repeat (12) @(posedge clk);
            #2;
            if (accept_log.size() != fifo_depth + 1) begin
                report_failure("bridge held the wrong number of words under back-pressure");
            end
            compare_bit("high_ready", high_ready, 1'b0);
            compare_bit("low_ready", low_ready, 1'b0);
            compare_bit("out_valid", out_valid, 1'b1);
            @(posedge clk);
            #1;
            out_ready = 1'b1;
        end
    join
    wait_drained();
    if (delivered - start_count != fifo_depth + 3) begin
        report_failure("words were lost or duplicated after back-pressure");
    end
endtask

`endif

/* bench/priority_bridge_tb.sv */
//////////////////////////////////////////////////
// inputs change 1 ns after the rising edge
// reference model samples at the falling edge
//////////////////////////////////////////////////
`timescale 1ns/100ps

module priority_bridge_tb;

    import bridge_cfg_pkg::*;
    import bridge_types_pkg::*;

    // rough cycle count of reset and the five tests, plus slack
    localparam int test_cycles  = 8 + 4 + 30 + 30 + 40 + 60;
    localparam int slack_cycles = 100;

    logic         clk;
    logic         rst_n;
    src_beat_t    high_beat;
    src_beat_t    low_beat;
    logic         high_ready;
    logic         low_ready;
    bridge_item_t out_item;
    logic         out_valid;
    logic         out_ready;

    integer seed = 32'hcacd;
    int     value_errors = 0;
    int     other_errors = 0;

    // reference model state
    bridge_item_t exp_queue[$];
    logic         accept_log[$];
    int           held = 0;
    int           model_wait = 0;
    int           delivered = 0;

    priority_bridge priority_bridge_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .high_beat  (high_beat),
        .low_beat   (low_beat),
        .high_ready (high_ready),
        .low_ready  (low_ready),
        .out_item   (out_item),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #5 clk = ~clk;

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic compare_item(input string name, input bridge_item_t actual,
                                input bridge_item_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0d ns %s: got from_high=%b data=%h, expected from_high=%b data=%h",
                     $time, name, actual.from_high, actual.data,
                     expected.from_high, expected.data);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("%0d ns: %s", $time, what);
    endtask

    // arbitration rule, readies and expected output order
    always @(negedge clk) begin
        logic         force_low;
        logic         model_full;
        logic         exp_high_ready;
        logic         exp_low_ready;
        bridge_item_t item;
        if (rst_n) begin
            // the bridge is full only with 4 words buffered and 1 on the output
            model_full     = (held == fifo_depth + 1);
            force_low      = low_beat.valid && (model_wait >= low_wait_limit);
            exp_high_ready = !model_full && !force_low;
            exp_low_ready  = !model_full && (!high_beat.valid || force_low);
            compare_bit("high_ready", high_ready, exp_high_ready);
            compare_bit("low_ready", low_ready, exp_low_ready);
            if (out_valid && out_ready) begin
                if (exp_queue.size() == 0) begin
                    report_failure("a word left the bridge while none was expected");
                end else begin
                    item = exp_queue.pop_front();
                    compare_item("out_item", out_item, item);
                    held--;
                    delivered++;
                end
            end
            if (high_beat.valid && exp_high_ready) begin
                item.from_high = 1'b1;
                item.data      = high_beat.data;
                exp_queue.push_back(item);
                held++;
            end else if (low_beat.valid && exp_low_ready) begin
                item.from_high = 1'b0;
                item.data      = low_beat.data;
                exp_queue.push_back(item);
                held++;
            end
            // grants as the bridge really gave them
            if (high_beat.valid && high_ready) begin
                accept_log.push_back(1'b1);
            end
            if (low_beat.valid && low_ready) begin
                accept_log.push_back(1'b0);
            end
            if (!low_beat.valid || exp_low_ready) begin
                model_wait = 0;
            end else if (high_beat.valid && exp_high_ready) begin
                model_wait++;
            end
        end
    end

    `include "bridge_tests.svh"

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        high_beat = '0;
        low_beat  = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        run_single_source();
        run_strict_priority();
        run_starvation_guard();
        run_back_pressure();
        if (exp_queue.size() != 0) begin
            report_failure("words were accepted but never delivered");
        end
        if (priority_bridge_inst.bridge_assertions_inst.fail_count != 0) begin
            report_failure("handshake assertions failed during the run");
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((test_cycles + slack_cycles) * 10);
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* design/bridge_cfg_pkg.sv */
//////////////////////////////////////////////////
// fifo_depth must equal 2**fifo_addr_width
// low_wait_limit must be at least 1
//////////////////////////////////////////////////

package bridge_cfg_pkg;

    // payload width of one word
    localparam int data_width = 32;

    // buffer entries between arbiter and egress
    localparam int fifo_depth = 4;

    // pointer width, pointers wrap on their own
    localparam int fifo_addr_width = 2;

    // consecutive high grants tolerated while low waits
    localparam int low_wait_limit = 3;

endpackage

/* design/bridge_types_pkg.sv */
//////////////////////////////////////////////////
// field order is fixed, benches rely on it
//////////////////////////////////////////////////

package bridge_types_pkg;

    import bridge_cfg_pkg::*;

    // one source offer, held until accepted
    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] data;
    } src_beat_t;

    // one buffered word with its origin
    typedef struct packed {
        logic                  from_high;
        logic [data_width-1:0] data;
    } bridge_item_t;

endpackage

/* design/egress_stage.sv */
//////////////////////////////////////////////////
// out_item holds until taken, one word per cycle max
//////////////////////////////////////////////////
`timescale 1ns/100ps

module egress_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  bridge_types_pkg::bridge_item_t head_item,
    input  logic                           empty,
    output logic                           pop,
    output bridge_types_pkg::bridge_item_t out_item,
    output logic                           out_valid,
    input  logic                           out_ready
);

    logic take;

    assign take = out_valid && out_ready;

    // refill when the register is free or drains now
    assign pop = !empty && (!out_valid || out_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            if (pop) begin
                out_valid <= 1'b1;
            end else if (take) begin
                out_valid <= 1'b0;
            end
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (pop) begin
            out_item <= head_item;
        end
    end

endmodule

/* design/item_fifo.sv */
//////////////////////////////////////////////////
// push is dropped when full unless a pop frees room
// pop on empty is ignored
//////////////////////////////////////////////////
`timescale 1ns/100ps

module item_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  bridge_types_pkg::bridge_item_t push_item,
    input  logic                           pop,
    output bridge_types_pkg::bridge_item_t head_item,
    output logic                           full,
    output logic                           empty
);

    import bridge_cfg_pkg::*;
    import bridge_types_pkg::*;

    bridge_item_t mem [fifo_depth];

    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0]   count;

    logic do_push;
    logic do_pop;

    assign full  = (count == (fifo_addr_width + 1)'(fifo_depth));
    assign empty = (count == '0);

    assign do_pop  = pop && !empty;
    // a same-cycle pop makes room even at full
    assign do_push = push && (!full || do_pop);

    assign head_item = mem[rd_ptr];

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/priority_arbiter.sv */
//////////////////////////////////////////////////
// readies are combinational from valid and full
// sources must hold their beat until accepted
//////////////////////////////////////////////////
`timescale 1ns/100ps

module priority_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bridge_types_pkg::src_beat_t   high_beat,
    input  bridge_types_pkg::src_beat_t   low_beat,
    input  logic                          full,
    output logic                          high_ready,
    output logic                          low_ready,
    output logic                          push,
    output bridge_types_pkg::bridge_item_t push_item
);

    import bridge_cfg_pkg::*;

    // high grants in a row while low was waiting
    logic [$clog2(low_wait_limit + 1) - 1:0] wait_cnt;

    logic force_low;
    logic high_take;
    logic low_take;

    // low has waited long enough, it wins this slot
    assign force_low = low_beat.valid && (wait_cnt >= low_wait_limit);

    always_comb begin
        high_ready = 1'b0;
        low_ready  = 1'b0;
        if (!full) begin
            high_ready = !force_low;
            // low only yields to a valid high beat
            low_ready  = !high_beat.valid || force_low;
        end
    end

    assign high_take = high_beat.valid && high_ready;
    assign low_take  = low_beat.valid && low_ready;

    assign push = high_take || low_take;

    always_comb begin
        push_item.from_high = high_take;
        if (high_take) begin
            push_item.data = high_beat.data;
        end else begin
            push_item.data = low_beat.data;
        end
    end

    // starvation guard counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else begin
            if (!low_beat.valid || low_take) begin
                wait_cnt <= '0;
            end else if (high_take) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/priority_bridge.sv */
//////////////////////////////////////////////////
// holds fifo_depth + 1 words under back-pressure
//////////////////////////////////////////////////
`timescale 1ns/100ps

module priority_bridge (
    input  logic                           clk,
    input  logic                           rst_n,
    input  bridge_types_pkg::src_beat_t    high_beat,
    input  bridge_types_pkg::src_beat_t    low_beat,
    output logic                           high_ready,
    output logic                           low_ready,
    output bridge_types_pkg::bridge_item_t out_item,
    output logic                           out_valid,
    input  logic                           out_ready
);

    import bridge_types_pkg::*;

    logic         push;
    bridge_item_t push_item;
    logic         full;
    bridge_item_t head_item;
    logic         empty;
    logic         pop;

    priority_arbiter priority_arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .high_beat  (high_beat),
        .low_beat   (low_beat),
        .full       (full),
        .high_ready (high_ready),
        .low_ready  (low_ready),
        .push       (push),
        .push_item  (push_item)
    );

    item_fifo item_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head_item (head_item),
        .full      (full),
        .empty     (empty)
    );

    egress_stage egress_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_item (head_item),
        .empty     (empty),
        .pop       (pop),
        .out_item  (out_item),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* tb.f */
+incdir+bench
design/bridge_cfg_pkg.sv
design/bridge_types_pkg.sv
design/priority_arbiter.sv
design/item_fifo.sv
design/egress_stage.sv
design/priority_bridge.sv
bench/bridge_assertions.sv
bench/priority_bridge_tb.sv
